/* logic/sd_cmd_pkg.sv */
package sd_cmd_pkg;

    // Command frame geometry
    localparam int CMD_INDEX_W = 6;
    localparam int CMD_ARG_W = 32;
    localparam int CMD_FRAME_W = 48;
    localparam int CRC7_W = 7;

    // Start bit, transmission bit, index and argument, all covered by the CRC
    localparam int CMD_HDR_W = 2 + CMD_INDEX_W + CMD_ARG_W;
    localparam int FRAME_CNT_W = $clog2(CMD_FRAME_W + 1);

    // Fixed bits of the frame
    localparam logic START_BIT = 1'b0;
    localparam logic TX_BIT = 1'b1;
    localparam logic END_BIT = 1'b1;

    // x^7 + x^3 + 1, top term implied
    localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09;

    // Command queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [QUEUE_PTR_W-1:0] QUEUE_LAST_PTR = QUEUE_PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [QUEUE_CNT_W-1:0] QUEUE_FULL_CNT = QUEUE_CNT_W'(QUEUE_DEPTH);

    // SD clock divisor
    localparam int DIVISOR_W = 8;

    // One queue entry
    typedef struct packed {
        logic [CMD_INDEX_W-1:0] index;
        logic [CMD_ARG_W-1:0]   arg;
    } cmd_req_t;

endpackage

/* logic/sd_host_reg_pkg.sv */
package sd_host_reg_pkg;

    localparam int REG_W = 32;
    localparam int ADDR_W = 8;

    // Register offsets
    localparam logic [ADDR_W-1:0] ARGUMENT_OFS = 8'h08;
    localparam logic [ADDR_W-1:0] COMMAND_OFS = 8'h0C;
    localparam logic [ADDR_W-1:0] DIVISOR_OFS = 8'h2C;
    localparam logic [ADDR_W-1:0] STATUS_OFS = 8'h30;
    localparam logic [ADDR_W-1:0] INT_ENABLE_OFS = 8'h34;

    // Status bits
    localparam int STATUS_W = 3;
    localparam int STAT_CMD_DONE = 0;
    localparam int STAT_OVERFLOW = 1;
    // Read only, mirrors the serializer
    localparam int STAT_CMD_BUSY = 2;

    // Command register layout
    typedef struct packed {
        logic [REG_W-sd_cmd_pkg::CMD_INDEX_W-1:0] rsvd;
        logic [sd_cmd_pkg::CMD_INDEX_W-1:0]       index;
    } cmd_word_t;

    // Divisor register layout
    typedef struct packed {
        logic [REG_W-sd_cmd_pkg::DIVISOR_W-1:0] rsvd;
        logic [sd_cmd_pkg::DIVISOR_W-1:0]       divisor;
    } div_word_t;

    // One register word, seen per target register
    typedef union packed {
        logic [sd_cmd_pkg::CMD_ARG_W-1:0] arg;
        cmd_word_t                        cmd;
        div_word_t                        div;
    } host_word_u;

endpackage

/* logic/sd_host_regs.sv */
`timescale 1ns/1ns

module sd_host_regs (
    input  logic                                 s00_axi_aclk,
    input  logic                                 rst_n_i,
    input  logic                                 reg_we_i,
    input  logic [sd_host_reg_pkg::ADDR_W-1:0]   reg_addr_i,
    input  logic [sd_host_reg_pkg::REG_W-1:0]    reg_wdata_i,
    output logic [sd_host_reg_pkg::REG_W-1:0]    reg_rdata_o,
    output logic                                 push_o,
    output sd_cmd_pkg::cmd_req_t                 push_req_o,
    input  logic                                 full_i,
    input  logic                                 done_i,
    input  logic                                 busy_i,
    output logic [sd_cmd_pkg::DIVISOR_W-1:0]     divisor_o,
    output logic                                 interrupt_o
);

    sd_host_reg_pkg::host_word_u            wword;
    sd_host_reg_pkg::host_word_u            rword;
    logic [sd_cmd_pkg::CMD_ARG_W-1:0]       arg_q;
    logic [sd_cmd_pkg::DIVISOR_W-1:0]       div_q;
    logic [sd_host_reg_pkg::STATUS_W-1:0]   int_en_q;
    logic [sd_host_reg_pkg::STATUS_W-1:0]   status;
    logic [sd_host_reg_pkg::STATUS_W-1:0]   clr;
    logic                                   done_q;
    logic                                   ovf_q;
    logic                                   cmd_wr;

    assign wword = reg_wdata_i;
    assign cmd_wr = reg_we_i && (reg_addr_i == sd_host_reg_pkg::COMMAND_OFS);

    // New command goes out with the last written argument
    assign push_o = cmd_wr && !full_i;
    assign push_req_o = '{index: wword.cmd.index, arg: arg_q};

    // Write one to clear
    assign clr = (reg_we_i && reg_addr_i == sd_host_reg_pkg::STATUS_OFS) ?
                 reg_wdata_i[sd_host_reg_pkg::STATUS_W-1:0] : '0;

    always_ff @(posedge s00_axi_aclk) begin
        if (reg_we_i && reg_addr_i == sd_host_reg_pkg::ARGUMENT_OFS) begin
            arg_q <= wword.arg;
        end
    end

    always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q <= '0;
            int_en_q <= '0;
            done_q <= 1'b0;
            ovf_q <= 1'b0;
        end else begin
            if (reg_we_i && reg_addr_i == sd_host_reg_pkg::DIVISOR_OFS) begin
                div_q <= wword.div.divisor;
            end
            if (reg_we_i && reg_addr_i == sd_host_reg_pkg::INT_ENABLE_OFS) begin
                int_en_q <= reg_wdata_i[sd_host_reg_pkg::STATUS_W-1:0];
            end
            // Set beats clear
            if (done_i) begin
                done_q <= 1'b1;
            end else if (clr[sd_host_reg_pkg::STAT_CMD_DONE]) begin
                done_q <= 1'b0;
            end
            if (cmd_wr && full_i) begin
                ovf_q <= 1'b1;
            end else if (clr[sd_host_reg_pkg::STAT_OVERFLOW]) begin
                ovf_q <= 1'b0;
            end
        end
    end

    always_comb begin
        status = '0;
        status[sd_host_reg_pkg::STAT_CMD_DONE] = done_q;
        status[sd_host_reg_pkg::STAT_OVERFLOW] = ovf_q;
        status[sd_host_reg_pkg::STAT_CMD_BUSY] = busy_i;
    end

    assign interrupt_o = |(status & int_en_q);
    assign divisor_o = div_q;

    // Readback mux
    always_comb begin
        rword = '0;
        case (reg_addr_i)
            sd_host_reg_pkg::ARGUMENT_OFS: rword.arg = arg_q;
            sd_host_reg_pkg::DIVISOR_OFS: rword.div.divisor = div_q;
            sd_host_reg_pkg::STATUS_OFS: rword.arg[sd_host_reg_pkg::STATUS_W-1:0] = status;
            sd_host_reg_pkg::INT_ENABLE_OFS: rword.arg[sd_host_reg_pkg::STATUS_W-1:0] = int_en_q;
            default: rword = '0;
        endcase
    end

    assign reg_rdata_o = rword;

endmodule

/* logic/sd_cmd_queue.sv */
`timescale 1ns/1ns

module sd_cmd_queue (
    input  logic                 s00_axi_aclk,
    input  logic                 rst_n_i,
    input  logic                 push_i,
    input  sd_cmd_pkg::cmd_req_t push_req_i,
    input  logic                 pop_i,
    output sd_cmd_pkg::cmd_req_t head_o,
    output logic                 full_o,
    output logic                 empty_o
);

    sd_cmd_pkg::cmd_req_t               mem [sd_cmd_pkg::QUEUE_DEPTH];
    logic [sd_cmd_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [sd_cmd_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [sd_cmd_pkg::QUEUE_CNT_W-1:0] count;
    logic                               do_push;
    logic                               do_pop;

    assign full_o = (count == sd_cmd_pkg::QUEUE_FULL_CNT);
    assign empty_o = (count == '0);
    assign do_push = push_i && !full_o;
    assign do_pop = pop_i && !empty_o;

    assign head_o = mem[rd_ptr];

    always_ff @(posedge s00_axi_aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req_i;
        end
    end

    always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == sd_cmd_pkg::QUEUE_LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == sd_cmd_pkg::QUEUE_LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/sd_cmd_serial.sv */
`timescale 1ns/1ns

module sd_cmd_serial (
    input  logic                             s00_axi_aclk,
    input  logic                             rst_n_i,
    input  logic [sd_cmd_pkg::DIVISOR_W-1:0] divisor_i,
    input  logic                             empty_i,
    input  sd_cmd_pkg::cmd_req_t             head_i,
    output logic                             pop_o,
    output logic                             done_o,
    output logic                             busy_o,
    output logic                             sd_clk_o,
    output logic                             sd_cmd_o,
    output logic                             sd_cmd_oe_o
);

    logic [sd_cmd_pkg::DIVISOR_W-1:0]   div_q;
    logic [sd_cmd_pkg::DIVISOR_W-1:0]   div_cnt;
    logic                               sd_clk_q;
    logic                               tick;
    logic                               fall;
    logic                               busy_q;
    logic                               done_q;
    logic                               cmd_q;
    logic                               oe_q;
    logic [sd_cmd_pkg::FRAME_CNT_W-1:0] bit_idx;
    logic [sd_cmd_pkg::CRC7_W-1:0]      crc_q;
    logic [sd_cmd_pkg::CRC7_W-1:0]      crc_shift;
    logic                               crc_fb;
    sd_cmd_pkg::cmd_req_t               req_q;
    logic [sd_cmd_pkg::CMD_HDR_W-1:0]   hdr;
    logic                               in_hdr;
    logic                               in_crc;
    logic                               last;
    logic                               cur_bit;

    // Half period is div_q + 1 system clocks
    assign tick = (div_cnt >= div_q);
    assign fall = tick && sd_clk_q;

    assign pop_o = !busy_q && !empty_i;

    assign hdr = {sd_cmd_pkg::START_BIT, sd_cmd_pkg::TX_BIT, req_q.index, req_q.arg};
    assign in_hdr = (bit_idx < sd_cmd_pkg::CMD_HDR_W);
    assign in_crc = !in_hdr && (bit_idx < sd_cmd_pkg::CMD_HDR_W + sd_cmd_pkg::CRC7_W);
    assign last = (bit_idx == sd_cmd_pkg::CMD_FRAME_W);

    // Next bit on the line, MSB first
    always_comb begin
        if (in_hdr) begin
            cur_bit = hdr[sd_cmd_pkg::CMD_HDR_W - 1 - bit_idx];
        end else if (in_crc) begin
            cur_bit = crc_q[sd_cmd_pkg::CRC7_W-1];
        end else begin
            cur_bit = sd_cmd_pkg::END_BIT;
        end
    end

    assign crc_shift = {crc_q[sd_cmd_pkg::CRC7_W-2:0], 1'b0};
    assign crc_fb = cur_bit ^ crc_q[sd_cmd_pkg::CRC7_W-1];

    // Free running SD clock
    always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q <= '0;
            div_cnt <= '0;
            sd_clk_q <= 1'b0;
        end else begin
            if (!busy_q) begin
                div_q <= divisor_i;
            end
            if (tick) begin
                div_cnt <= '0;
                sd_clk_q <= ~sd_clk_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge s00_axi_aclk) begin
        if (pop_o) begin
            req_q <= head_i;
        end
    end

    // Frame sequencer, one bit per falling edge
    always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cmd_q <= 1'b1;
            oe_q <= 1'b0;
            bit_idx <= '0;
            crc_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (pop_o) begin
                busy_q <= 1'b1;
                bit_idx <= '0;
                crc_q <= '0;
            end else if (busy_q && fall) begin
                if (last) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                    oe_q <= 1'b0;
                    cmd_q <= 1'b1;
                end else begin
                    cmd_q <= cur_bit;
                    oe_q <= 1'b1;
                    bit_idx <= bit_idx + 1'b1;
                    // CRC runs over the header, then shifts itself out
                    if (in_hdr) begin
                        crc_q <= crc_shift ^ (crc_fb ? sd_cmd_pkg::CRC7_POLY : '0);
                    end else begin
                        crc_q <= crc_shift;
                    end
                end
            end
        end
    end

    assign done_o = done_q;
    assign busy_o = busy_q;
    assign sd_clk_o = sd_clk_q;
    assign sd_cmd_o = cmd_q;
    assign sd_cmd_oe_o = oe_q;

endmodule

/* logic/sd_cmd_ctrl.sv */
`timescale 1ns/1ns

module sd_cmd_ctrl (
    input  logic                               s00_axi_aclk,
    input  logic                               rst_n_i,
    input  logic                               reg_we_i,
    input  logic [sd_host_reg_pkg::ADDR_W-1:0] reg_addr_i,
    input  logic [sd_host_reg_pkg::REG_W-1:0]  reg_wdata_i,
    output logic [sd_host_reg_pkg::REG_W-1:0]  reg_rdata_o,
    output logic                               sd_clk_o,
    output logic                               sd_cmd_o,
    output logic                               sd_cmd_oe_o,
    output logic                               interrupt_o
);

    logic                             push;
    sd_cmd_pkg::cmd_req_t             push_req;
    logic                             full;
    logic                             empty;
    sd_cmd_pkg::cmd_req_t             head;
    logic                             pop;
    logic                             done;
    logic                             busy;
    logic [sd_cmd_pkg::DIVISOR_W-1:0] divisor;

    sd_host_regs sd_host_regs_i (
        .s00_axi_aclk (s00_axi_aclk),
        .rst_n_i      (rst_n_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .push_o       (push),
        .push_req_o   (push_req),
        .full_i       (full),
        .done_i       (done),
        .busy_i       (busy),
        .divisor_o    (divisor),
        .interrupt_o  (interrupt_o)
    );

    sd_cmd_queue sd_cmd_queue_i (
        .s00_axi_aclk (s00_axi_aclk),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .push_req_i   (push_req),
        .pop_i        (pop),
        .head_o       (head),
        .full_o       (full),
        .empty_o      (empty)
    );

    sd_cmd_serial sd_cmd_serial_i (
        .s00_axi_aclk (s00_axi_aclk),
        .rst_n_i      (rst_n_i),
        .divisor_i    (divisor),
        .empty_i      (empty),
        .head_i       (head),
        .pop_o        (pop),
        .done_o       (done),
        .busy_o       (busy),
        .sd_clk_o     (sd_clk_o),
        .sd_cmd_o     (sd_cmd_o),
        .sd_cmd_oe_o  (sd_cmd_oe_o)
    );

endmodule

/* testbench/sd_cmd_ctrl_props.sv */
`timescale 1ns/1ns

module sd_cmd_ctrl_props (
    input logic s00_axi_aclk,
    input logic rst_n_i,
    input logic pop_i,
    input logic done_i,
    input logic busy_i,
    input logic cmd_i,
    input logic cmd_oe_i
);

    int fails = 0;

    // Line idles high
    idle_high: assert property (@(posedge s00_axi_aclk) disable iff (!rst_n_i)
        !cmd_oe_i |-> cmd_i)
        else begin
            $error("CMD line low while its driver is off");
            fails++;
        end

    start_bit: assert property (@(posedge s00_axi_aclk) disable iff (!rst_n_i)
        $rose(cmd_oe_i) |-> !cmd_i)
        else begin
            $error("first bit of a frame is not the start bit");
            fails++;
        end

    done_pulse: assert property (@(posedge s00_axi_aclk) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else begin
            $error("done lasted more than one cycle");
            fails++;
        end

    // A pop starts a frame, never while one is running
    pop_idle: assert property (@(posedge s00_axi_aclk) disable iff (!rst_n_i)
        pop_i |-> (!busy_i && !cmd_oe_i) ##1 busy_i)
        else begin
            $error("pop while the serializer is busy, or a pop that started no frame");
            fails++;
        end

endmodule

bind sd_cmd_serial sd_cmd_ctrl_props props_i (
    .s00_axi_aclk (s00_axi_aclk),
    .rst_n_i      (rst_n_i),
    .pop_i        (pop_o),
    .done_i       (done_o),
    .busy_i       (busy_o),
    .cmd_i        (sd_cmd_o),
    .cmd_oe_i     (sd_cmd_oe_o)
);

/* testbench/sd_cmd_ctrl_tb.sv */
`timescale 1ns/1ns

module sd_cmd_ctrl_tb;

    localparam int FRAME_W = sd_cmd_pkg::CMD_FRAME_W;
    // Frames over all tests, at the slowest divisor any of them uses
    localparam int FRAMES_TOTAL = 27;
    localparam int WORST_DIV = 3;
    localparam int WATCHDOG_NS = 2 * FRAMES_TOTAL * FRAME_W * 2 * (WORST_DIV + 1) * 40;

    logic                               s00_axi_aclk;
    logic                               rst_n;
    logic                               reg_we;
    logic [sd_host_reg_pkg::ADDR_W-1:0] reg_addr;
    logic [sd_host_reg_pkg::REG_W-1:0]  reg_wdata;
    logic [sd_host_reg_pkg::REG_W-1:0]  reg_rdata;
    logic                               sd_clk;
    logic                               sd_cmd;
    logic                               sd_cmd_oe;
    logic                               interrupt;
    integer                             seed;
    int                                 errors;
    int                                 checks;
    int                                 tests_failed;
    sd_cmd_pkg::cmd_req_t               exp_q[$];
    logic [FRAME_W-1:0]                 rx_q[$];
    logic [FRAME_W-1:0]                 rx_bits;
    int                                 rx_cnt;
    logic                               prev_clk;
    logic                               prev_oe;
    int                                 rise_total;
    int                                 cyc_since_rise;
    int                                 last_period;

    sd_cmd_ctrl dut_i (
        .s00_axi_aclk (s00_axi_aclk),
        .rst_n_i      (rst_n),
        .reg_we_i     (reg_we),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_rdata_o  (reg_rdata),
        .sd_clk_o     (sd_clk),
        .sd_cmd_o     (sd_cmd),
        .sd_cmd_oe_o  (sd_cmd_oe),
        .interrupt_o  (interrupt)
    );

    always #20 s00_axi_aclk = ~s00_axi_aclk;

    // CRC7 over the 40 header bits, x^7 + x^3 + 1
    function automatic logic [6:0] crc7(input logic [39:0] hdr);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = hdr[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'b000_1001 : 7'b0);
        end
        return crc;
    endfunction

    function automatic logic [FRAME_W-1:0] expected_frame(input sd_cmd_pkg::cmd_req_t req);
        logic [39:0] hdr;
        hdr = {2'b01, req.index, req.arg};
        return {hdr, crc7(hdr), 1'b1};
    endfunction

    // Frame plus pop latency, doubled
    function automatic int frame_cycles(input int div);
        return 2 * (FRAME_W + 2) * 2 * (div + 1);
    endfunction

    // Line monitor, sampled mid cycle
    always @(negedge s00_axi_aclk) begin
        cyc_since_rise++;
        if (sd_clk && !prev_clk) begin
            last_period = cyc_since_rise;
            cyc_since_rise = 0;
            rise_total++;
            if (sd_cmd_oe) begin
                rx_bits = {rx_bits[FRAME_W-2:0], sd_cmd};
                rx_cnt++;
            end
        end
        if (prev_oe && !sd_cmd_oe) begin
            if (rx_cnt != FRAME_W) begin
                $display("error at %0t ns: frame carried %0d bits", $time, rx_cnt);
                errors++;
            end
            rx_q.push_back(rx_bits);
            rx_cnt = 0;
        end
        prev_clk = sd_clk;
        prev_oe = sd_cmd_oe;
    end

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge s00_axi_aclk);
        reg_we <= 1'b1;
        reg_addr <= addr;
        reg_wdata <= data;
    endtask

    task automatic bus_idle();
        @(posedge s00_axi_aclk);
        reg_we <= 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge s00_axi_aclk);
        reg_we <= 1'b0;
        reg_addr <= addr;
        @(negedge s00_axi_aclk);
        data = reg_rdata;
    endtask

    task automatic set_divisor(input logic [7:0] div);
        sd_host_reg_pkg::host_word_u w;
        w = '0;
        w.div.divisor = div;
        reg_write(sd_host_reg_pkg::DIVISOR_OFS, w);
        bus_idle();
    endtask

    task automatic send_cmd(input logic [5:0] index, input logic [31:0] arg);
        sd_host_reg_pkg::host_word_u w;
        sd_cmd_pkg::cmd_req_t        req;
        w = '0;
        w.cmd.index = index;
        req.index = index;
        req.arg = arg;
        reg_write(sd_host_reg_pkg::ARGUMENT_OFS, arg);
        reg_write(sd_host_reg_pkg::COMMAND_OFS, w);
        bus_idle();
        exp_q.push_back(req);
    endtask

    task automatic check_frames(input int limit);
        int                 waited;
        int                 n;
        logic [FRAME_W-1:0] want;
        logic [FRAME_W-1:0] got;
        waited = 0;
        n = exp_q.size();
        while (rx_q.size() < n && waited < limit) begin
            @(posedge s00_axi_aclk);
            waited++;
        end
        while (exp_q.size() > 0) begin
            want = expected_frame(exp_q.pop_front());
            checks++;
            if (rx_q.size() == 0) begin
                $display("Frame %012h never appeared on the CMD line", want);
                errors++;
            end else begin
                got = rx_q.pop_front();
                if (got != want) begin
                    $display("error at %0t ns: frame %012h, expected %012h", $time, got, want);
                    errors++;
                end
            end
        end
    endtask

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic wait_rises(input int n);
        int target;
        target = rise_total + n;
        while (rise_total < target) begin
            @(posedge s00_axi_aclk);
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %0d %s passed", num, name);
        end else begin
            $display("test %0d %s failed with %0d errors", num, name, errors - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0]                 rd;
        logic [7:0]                  div;
        sd_cmd_pkg::cmd_req_t        req;
        sd_host_reg_pkg::host_word_u w;
        int                          err0;
        seed = 32'hdc8c_cee1;
        s00_axi_aclk = 1'b0;
        rst_n = 1'b0;
        reg_we = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        errors = 0;
        checks = 0;
        tests_failed = 0;
        rx_cnt = 0;
        rise_total = 0;
        cyc_since_rise = 0;
        last_period = 0;
        prev_clk = 1'b0;
        prev_oe = 1'b0;
        repeat (3) @(posedge s00_axi_aclk);
        rst_n <= 1'b1;

        err0 = errors;
        @(negedge s00_axi_aclk);
        expect_eq("sd_cmd_oe_o", sd_cmd_oe, 0);
        expect_eq("sd_cmd_o", sd_cmd, 1);
        expect_eq("interrupt_o", interrupt, 0);
        reg_read(sd_host_reg_pkg::STATUS_OFS, rd);
        expect_eq("STATUS", rd, 0);
        end_test(1, "reset state", err0);

        err0 = errors;
        repeat (20) begin
            div = 8'($random(seed) & 3);
            req.index = 6'($random(seed));
            req.arg = $random(seed);
            set_divisor(div);
            send_cmd(req.index, req.arg);
            check_frames(frame_cycles(div));
        end
        end_test(2, "random frames", err0);

        // Back to back burst, sixth write overflows
        err0 = errors;
        set_divisor(0);
        req.arg = $random(seed);
        reg_write(sd_host_reg_pkg::ARGUMENT_OFS, req.arg);
        w = '0;
        for (int i = 0; i < 6; i++) begin
            req.index = 6'($random(seed));
            w.cmd.index = req.index;
            reg_write(sd_host_reg_pkg::COMMAND_OFS, w);
            if (i < 5) begin
                exp_q.push_back(req);
            end
        end
        bus_idle();
        check_frames(5 * frame_cycles(0));
        repeat (frame_cycles(0)) @(posedge s00_axi_aclk);
        checks++;
        if (rx_q.size() != 0) begin
            $display("A sixth frame came out although its write should have been dropped");
            errors++;
            rx_q.delete();
        end
        reg_read(sd_host_reg_pkg::STATUS_OFS, rd);
        expect_eq("overflow bit", rd[sd_host_reg_pkg::STAT_OVERFLOW], 1);
        reg_write(sd_host_reg_pkg::STATUS_OFS, 1 << sd_host_reg_pkg::STAT_OVERFLOW);
        reg_read(sd_host_reg_pkg::STATUS_OFS, rd);
        expect_eq("overflow bit after clear", rd[sd_host_reg_pkg::STAT_OVERFLOW], 0);
        end_test(3, "burst and overflow", err0);

        err0 = errors;
        reg_write(sd_host_reg_pkg::STATUS_OFS, 32'h3);
        reg_write(sd_host_reg_pkg::INT_ENABLE_OFS, 1 << sd_host_reg_pkg::STAT_CMD_DONE);
        bus_idle();
        @(negedge s00_axi_aclk);
        expect_eq("interrupt_o before the frame", interrupt, 0);
        send_cmd(6'($random(seed)), $random(seed));
        check_frames(frame_cycles(0));
        repeat (2) @(negedge s00_axi_aclk);
        expect_eq("interrupt_o after a frame", interrupt, 1);
        reg_write(sd_host_reg_pkg::STATUS_OFS, 1 << sd_host_reg_pkg::STAT_CMD_DONE);
        bus_idle();
        @(negedge s00_axi_aclk);
        expect_eq("interrupt_o after clear", interrupt, 0);
        reg_write(sd_host_reg_pkg::INT_ENABLE_OFS, 0);
        send_cmd(6'($random(seed)), $random(seed));
        check_frames(frame_cycles(0));
        repeat (2) @(negedge s00_axi_aclk);
        expect_eq("interrupt_o while masked", interrupt, 0);
        reg_write(sd_host_reg_pkg::STATUS_OFS, 32'h3);
        bus_idle();
        end_test(4, "interrupt", err0);

        err0 = errors;
        repeat (6) begin
            div = 8'($random(seed) & 7);
            set_divisor(div);
            wait_rises(3);
            expect_eq("SD clock period", last_period, 2 * (div + 1));
            reg_read(sd_host_reg_pkg::DIVISOR_OFS, rd);
            expect_eq("DIVISOR", rd, div);
        end
        end_test(5, "clock divisor", err0);

        checks++;
        if (dut_i.sd_cmd_serial_i.props_i.fails != 0) begin
            $display("The serializer checker flagged %0d assertion failures",
                     dut_i.sd_cmd_serial_i.props_i.fails);
            errors += dut_i.sd_cmd_serial_i.props_i.fails;
        end

        $display("tests run: 5, tests failed: %0d, checks: %0d, errors: %0d",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("The run took longer than %0d ns and was stopped by the watchdog", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* sd_cmd_ctrl.f */
logic/sd_cmd_pkg.sv
logic/sd_host_reg_pkg.sv
logic/sd_host_regs.sv
logic/sd_cmd_queue.sv
logic/sd_cmd_serial.sv
logic/sd_cmd_ctrl.sv
testbench/sd_cmd_ctrl_props.sv
testbench/sd_cmd_ctrl_tb.sv
